// ==== src/yuv_stream_pkg.sv ====
package yuv_stream_pkg;

   // stream type codes carried next to every item
   localparam int dtype_width = 4;

   typedef logic [dtype_width-1:0] dtype_t;

   // one colour channel
   typedef logic [7:0] pixel_t;

   localparam dtype_t dtype_frame_start = 4'd1;
   localparam dtype_t dtype_frame_end   = 4'd2;
   localparam dtype_t dtype_row_start   = 4'd3;
   localparam dtype_t dtype_row_end     = 4'd4;
   localparam dtype_t dtype_pixel       = 4'd8;

   // only the pixel code has bit 3 set
   localparam dtype_t dtype_pixel_mask  = 4'b1000;

   // image geometry
   localparam int max_cols  = 1288;
   localparam int col_width = 11;

   // byte lanes of the output path
   localparam int chunk_width = 24;
   localparam int word_width  = 32;
   localparam int obuf_width  = word_width + chunk_width;
   localparam int word_bytes  = word_width / 8;

   // enough for a partial word plus one full chunk, counted in bytes
   localparam int fill_width  = $clog2(obuf_width / 8 + 1);

endpackage

// ==== src/stream_config.sv ====
`timescale 1ns/10ps

module stream_config
   import yuv_stream_pkg::*;
(
   input  logic   clk,
   input  logic   resetb,
   input  logic   dvi,
   input  dtype_t dtypei,
   input  logic   raw_mode,
   input  logic   enable_420,
   output logic   raw_mode_q,
   output logic   enable_420_q
);

   logic frame_start;

   // the live mode pins may toggle at any time
   assign frame_start = dvi && (dtypei == dtype_frame_start);

   // mode is captured on the frame start marker and held for the whole frame,
   // so the pixels after the marker already see the new setting
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         // both low selects full yuv mode
         raw_mode_q   <= 1'b0;
         enable_420_q <= 1'b0;
      end else begin
         if (frame_start) begin
            raw_mode_q   <= raw_mode;
            enable_420_q <= enable_420;
         end
      end
   end

endmodule

// ==== src/yuv420_subsampler.sv ====
`timescale 1ns/10ps

module yuv420_subsampler
   import yuv_stream_pkg::*;
(
   input  logic                   clk,
   input  logic                   resetb,
   input  logic                   dvi,
   input  dtype_t                 dtypei,
   input  pixel_t                 yi,
   input  pixel_t                 ui,
   input  pixel_t                 vi,
   input  logic                   raw_mode_q,
   input  logic                   enable_420_q,
   output logic                   chunk_dv,
   output dtype_t                 chunk_dtype,
   output logic [chunk_width-1:0] chunk,
   output logic                   chunk_len
);

   logic                   pixel_in;
   logic                   frame_start;
   logic                   row_start;
   logic                   row_end;
   logic [col_width-1:0]   col;
   logic [col_width-1:0]   row;

   // chroma of the previous row, one entry per column
   pixel_t                 u_line [max_cols];
   pixel_t                 v_line [max_cols];

   pixel_t                 above_u;
   pixel_t                 above_v;
   pixel_t                 above_left_u;
   pixel_t                 above_left_v;
   pixel_t                 left_u;
   pixel_t                 left_v;

   logic [9:0]             u_sum;
   logic [9:0]             v_sum;
   pixel_t                 u_avg;
   pixel_t                 v_avg;
   logic                   avg_pos;

   logic [chunk_width-1:0] next_chunk;
   logic                   next_len;

   assign pixel_in    = dvi && |(dtypei & dtype_pixel_mask);
   assign frame_start = dvi && (dtypei == dtype_frame_start);
   assign row_start   = dvi && (dtypei == dtype_row_start);
   assign row_end     = dvi && (dtypei == dtype_row_end);

   // previous row at this column, read before this pixel overwrites it
   assign above_u = u_line[col];
   assign above_v = v_line[col];

   // 2x2 block sum, floor divide by 4
   assign u_sum = 10'(left_u) + 10'(above_left_u) + 10'(above_u) + 10'(ui);
   assign v_sum = 10'(left_v) + 10'(above_left_v) + 10'(above_v) + 10'(vi);
   assign u_avg = u_sum[9:2];
   assign v_avg = v_sum[9:2];

   // bottom right corner of each block
   assign avg_pos = row[0] && col[0];

   // Y always leads the chunk in the top lane; one byte chunks
   // leave the two lower lanes zero
   always_comb begin
      next_chunk = '0;
      next_len   = 1'b0;
      if (pixel_in) begin
         if (raw_mode_q) begin
            next_chunk = {yi, 16'h0000};
         end else if (!enable_420_q) begin
            next_chunk = {yi, ui, vi};
            next_len   = 1'b1;
         end else if (avg_pos) begin
            next_chunk = {yi, u_avg, v_avg};
            next_len   = 1'b1;
         end else begin
            next_chunk = {yi, 16'h0000};
         end
      end
   end

   // position counters and the chunk strobe
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         col         <= '0;
         row         <= '0;
         chunk_dv    <= 1'b0;
         chunk_dtype <= '0;
         chunk_len   <= 1'b0;
      end else begin
         chunk_dv    <= dvi;
         chunk_dtype <= dtypei;
         chunk_len   <= next_len;

         if (frame_start) begin
            row <= '0;
         end else if (row_end) begin
            row <= row + 1'b1;
         end

         if (row_start) begin
            col <= '0;
         end else if (pixel_in) begin
            col <= col + 1'b1;
         end
      end
   end

   // line buffer and neighbour registers
   always_ff @(posedge clk) begin
      chunk <= next_chunk;
      if (pixel_in) begin
         u_line[col]  <= ui;
         v_line[col]  <= vi;
         left_u       <= ui;
         left_v       <= vi;
         above_left_u <= above_u;
         above_left_v <= above_v;
      end
   end

endmodule

// ==== src/word_packer.sv ====
`timescale 1ns/10ps

module word_packer
   import yuv_stream_pkg::*;
(
   input  logic                   clk,
   input  logic                   resetb,
   input  logic                   chunk_dv,
   input  dtype_t                 chunk_dtype,
   input  logic [chunk_width-1:0] chunk,
   input  logic                   chunk_len,
   output logic                   dvo,
   output dtype_t                 dtypeo,
   output logic [word_width-1:0]  datao
);

   logic                  pixel_in;
   logic                  frame_start;
   logic                  frame_end;
   logic                  flush;
   logic                  flushed;
   logic                  word_done;
   logic [fill_width-1:0] fill;
   logic [fill_width-1:0] next_fill;
   logic [fill_width-1:0] rem_fill;
   logic [obuf_width-1:0] obuf;
   logic [obuf_width-1:0] next_obuf;
   logic [obuf_width-1:0] aligned;
   logic [word_width-1:0] word;

   assign pixel_in    = chunk_dv && |(chunk_dtype & dtype_pixel_mask);
   assign frame_start = chunk_dv && (chunk_dtype == dtype_frame_start);
   assign frame_end   = chunk_dv && (chunk_dtype == dtype_frame_end);
   assign flush       = frame_end && (fill != '0);

   // newest byte sits in the lowest lane of the accumulator
   always_comb begin
      next_obuf = obuf;
      next_fill = fill;
      if (flush) begin
         // move pending bytes to the top of the word, zeros pad the tail
         next_obuf = obuf << {fill_width'(word_bytes) - fill, 3'b000};
         next_fill = fill_width'(word_bytes);
      end else if (pixel_in) begin
         if (chunk_len) begin
            next_obuf = {obuf[obuf_width-chunk_width-1:0], chunk};
            next_fill = fill + fill_width'(3);
         end else begin
            next_obuf = {obuf[obuf_width-9:0], chunk[chunk_width-1 -: 8]};
            next_fill = fill + fill_width'(1);
         end
      end
   end

   // oldest four bytes, remainder stays behind in the low lanes
   assign word_done = next_fill >= fill_width'(word_bytes);
   assign rem_fill  = next_fill - fill_width'(word_bytes);
   assign aligned   = next_obuf >> {rem_fill, 3'b000};
   assign word      = aligned[word_width-1:0];

   always_ff @(posedge clk) begin
      obuf <= next_obuf;
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         fill    <= '0;
         flushed <= 1'b0;
         dvo     <= 1'b0;
         dtypeo  <= '0;
         datao   <= '0;
      end else begin
         flushed <= flush;

         // the source leaves one idle slot after a frame end
         if (flushed) begin
            dvo    <= 1'b1;
            dtypeo <= dtype_frame_end;
            datao  <= '0;
         end else if (flush) begin
            dvo    <= 1'b1;
            dtypeo <= dtype_pixel;
            datao  <= {<<8{word}};
         end else if (pixel_in) begin
            dvo    <= word_done;
            dtypeo <= chunk_dtype;
            if (word_done) begin
               // first byte ends up in bits 7:0
               datao <= {<<8{word}};
            end
         end else if (chunk_dv) begin
            // markers pass through with an empty payload
            dvo    <= 1'b1;
            dtypeo <= chunk_dtype;
            datao  <= '0;
         end else begin
            dvo <= 1'b0;
         end

         if (frame_start) begin
            fill <= '0;
         end else if (word_done) begin
            fill <= rem_fill;
         end else begin
            fill <= next_fill;
         end
      end
   end

endmodule

// ==== src/yuv420_stream.sv ====
`timescale 1ns/10ps

module yuv420_stream
   import yuv_stream_pkg::*;
(
   input  logic                  clk,
   input  logic                  resetb,
   input  logic                  raw_mode,
   input  logic                  enable_420,
   input  logic                  dvi,
   input  dtype_t                dtypei,
   input  pixel_t                yi,
   input  pixel_t                ui,
   input  pixel_t                vi,
   output logic                  dvo,
   output dtype_t                dtypeo,
   output logic [word_width-1:0] datao
);

   logic                   raw_mode_q;
   logic                   enable_420_q;
   logic                   chunk_dv;
   dtype_t                 chunk_dtype;
   logic [chunk_width-1:0] chunk;
   logic                   chunk_len;

   // mode held per frame
   stream_config stream_config_i (
      .clk          (clk),
      .resetb       (resetb),
      .dvi          (dvi),
      .dtypei       (dtypei),
      .raw_mode     (raw_mode),
      .enable_420   (enable_420),
      .raw_mode_q   (raw_mode_q),
      .enable_420_q (enable_420_q)
   );

   // one chunk per input item, one cycle later
   yuv420_subsampler yuv420_subsampler_i (
      .clk          (clk),
      .resetb       (resetb),
      .dvi          (dvi),
      .dtypei       (dtypei),
      .yi           (yi),
      .ui           (ui),
      .vi           (vi),
      .raw_mode_q   (raw_mode_q),
      .enable_420_q (enable_420_q),
      .chunk_dv     (chunk_dv),
      .chunk_dtype  (chunk_dtype),
      .chunk        (chunk),
      .chunk_len    (chunk_len)
   );

   word_packer word_packer_i (
      .clk         (clk),
      .resetb      (resetb),
      .chunk_dv    (chunk_dv),
      .chunk_dtype (chunk_dtype),
      .chunk       (chunk),
      .chunk_len   (chunk_len),
      .dvo         (dvo),
      .dtypeo      (dtypeo),
      .datao       (datao)
   );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
   output logic clk,
   output logic resetb
);

   // 8 ns period
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      resetb = 1'b1;
      #1;
      resetb = 1'b0;
      repeat (4) @(posedge clk);
      resetb <= 1'b1;
   end

endmodule

// ==== tb/yuv420_stream_properties.sv ====
`timescale 1ns/10ps

module yuv420_stream_properties
   import yuv_stream_pkg::*;
(
   input logic                  clk,
   input logic                  resetb,
   input logic                  dvi,
   input logic                  chunk_dv,
   input dtype_t                chunk_dtype,
   input logic                  dvo,
   input dtype_t                dtypeo,
   input logic [word_width-1:0] datao
);

   logic seen_input;
   int   fail_count = 0;

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         seen_input <= 1'b0;
      end else if (dvi) begin
         seen_input <= 1'b1;
      end
   end

   // quiet outputs through reset and up to the first item
   assert property (@(posedge clk) !seen_input |-> (!dvo && dtypeo == '0 && datao == '0))
      else begin
         $error("outputs not zero before the first input item");
         fail_count++;
      end

   // markers never carry payload
   assert property (@(posedge clk) disable iff (!resetb)
      (dvo && !dtypeo[3]) |-> datao == '0)
      else begin
         $error("marker carries a nonzero payload");
         fail_count++;
      end

   // frame end leaves directly or right behind its pad word
   assert property (@(posedge clk) disable iff (!resetb)
      (chunk_dv && chunk_dtype == dtype_frame_end) |=>
         (dvo && dtypeo == dtype_frame_end) or
         ((dvo && dtypeo == dtype_pixel) ##1 (dvo && dtypeo == dtype_frame_end)))
      else begin
         $error("frame end marker not emitted within two cycles");
         fail_count++;
      end

   // a pad word holds at most three bytes, so its last lane is zero
   assert property (@(posedge clk) disable iff (!resetb)
      (dvo && dtypeo == dtype_pixel) ##1 (dvo && dtypeo == dtype_frame_end)
         |-> $past(datao[31:24]) == 8'h00)
      else begin
         $error("pad word before frame end is not zero filled");
         fail_count++;
      end

endmodule

// ==== tb/yuv420_stream_tb.sv ====
`timescale 1ns/10ps

module yuv420_stream_tb
   import yuv_stream_pkg::*;
();

   logic                              clk;
   logic                              resetb;
   logic                              raw_mode;
   logic                              enable_420;
   logic                              dvi;
   dtype_t                            dtypei;
   pixel_t                            yi;
   pixel_t                            ui;
   pixel_t                            vi;
   logic                              dvo;
   dtype_t                            dtypeo;
   logic [word_width-1:0]             datao;

   // expected output items with the type code above the word
   logic [dtype_width+word_width-1:0] exp_q [$];
   logic [dtype_width+word_width-1:0] exp_item;
   pixel_t                            byte_q [$];
   int                                errors = 0;
   int                                wait_cycles;

   tb_clock_gen tb_clock_gen_i (.clk(clk), .resetb(resetb));

   yuv420_stream yuv420_stream_i (.*);

   bind yuv420_stream yuv420_stream_properties props_i (.*);

   task automatic send_item(input dtype_t code, input pixel_t y, input pixel_t u,
                            input pixel_t v);
      @(posedge clk);
      dvi    <= 1'b1;
      dtypei <= code;
      yi     <= y;
      ui     <= u;
      vi     <= v;
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      dvi <= 1'b0;
   endtask

   task automatic send_marker(input dtype_t code);
      send_item(code, 8'h00, 8'h00, 8'h00);
      exp_q.push_back({code, 32'h0000_0000});
   endtask

   // first byte of a word lands in bits 7:0
   task automatic push_byte(input pixel_t b);
      byte_q.push_back(b);
      if (byte_q.size() == word_bytes) begin
         exp_q.push_back({dtype_pixel, byte_q[3], byte_q[2], byte_q[1], byte_q[0]});
         byte_q.delete();
      end
   endtask

   // flip drops enable_420 mid frame without changing this frame's format
   task automatic send_frame(input int rows, input int cols, input logic raw,
                             input logic en, input logic flip);
      pixel_t pu [6][7];
      pixel_t pv [6][7];
      pixel_t y;
      int     avg_u;
      int     avg_v;
      send_marker(dtype_frame_start);
      raw_mode   <= raw;
      enable_420 <= en;
      for (int r = 0; r < rows; r++) begin
         send_marker(dtype_row_start);
         for (int c = 0; c < cols; c++) begin
            y        = 8'($urandom);
            pu[r][c] = 8'($urandom);
            pv[r][c] = 8'($urandom);
            send_item(dtype_pixel, y, pu[r][c], pv[r][c]);
            if (flip && r == 1 && c == 2) begin
               enable_420 <= !en;
            end
            push_byte(y);
            if (!raw && !en) begin
               push_byte(pu[r][c]);
               push_byte(pv[r][c]);
            end else if (!raw && r % 2 == 1 && c % 2 == 1) begin
               avg_u = (pu[r-1][c-1] + pu[r-1][c] + pu[r][c-1] + pu[r][c]) / 4;
               avg_v = (pv[r-1][c-1] + pv[r-1][c] + pv[r][c-1] + pv[r][c]) / 4;
               push_byte(8'(avg_u));
               push_byte(8'(avg_v));
            end
         end
         send_marker(dtype_row_end);
      end
      while (byte_q.size() != 0) begin
         push_byte(8'h00);
      end
      send_marker(dtype_frame_end);
      // the packer needs a free slot for the pad word
      idle_cycle();
   endtask

   always @(negedge clk) begin
      if (resetb && dvo) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("output item appeared with nothing expected");
         end else begin
            exp_item = exp_q.pop_front();
            assert (dtypeo == exp_item[35:32]) else begin
               errors++;
               $display("FAILED dtypeo: got %h, expected %h", dtypeo, exp_item[35:32]);
            end
            assert (datao == exp_item[31:0]) else begin
               errors++;
               $display("FAILED datao: got %h, expected %h", datao, exp_item[31:0]);
            end
         end
      end
   end

   initial begin
      raw_mode   = 1'b0;
      enable_420 = 1'b0;
      dvi        = 1'b0;
      dtypei     = '0;
      yi         = '0;
      ui         = '0;
      vi         = '0;
      void'($urandom(93742));

      wait_cycles = 0;
      @(posedge clk);
      while (!resetb && wait_cycles < 20) begin
         @(posedge clk);
         wait_cycles++;
      end
      if (!resetb) begin
         errors++;
         $display("reset was never released");
      end
      repeat (3) idle_cycle();

      // raw wins over 4:2:0 and 25 bytes leave a pad word
      send_frame(5, 5, 1'b1, 1'b1, 1'b0);
      send_frame(4 + $urandom % 3, 5 + $urandom % 3, 1'b0, 1'b0, 1'b0);
      send_frame(4 + $urandom % 3, 5 + $urandom % 3, 1'b0, 1'b1, 1'b0);
      send_frame(4 + $urandom % 3, 5 + $urandom % 3, 1'b0, 1'b1, 1'b1);
      send_frame(4 + $urandom % 3, 5 + $urandom % 3, 1'b0, 1'b0, 1'b0);
      send_frame(5, 5, 1'b0, 1'b1, 1'b0);

      wait_cycles = 0;
      while (exp_q.size() != 0 && wait_cycles < 100) begin
         @(posedge clk);
         wait_cycles++;
      end
      if (exp_q.size() != 0) begin
         errors++;
         $display("timed out with %0d expected output items missing", exp_q.size());
      end
      repeat (4) idle_cycle();

      $display("check errors: %0d, protocol errors: %0d", errors,
               yuv420_stream_i.props_i.fail_count);
      if (errors == 0 && yuv420_stream_i.props_i.fail_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== yuv420_stream.f ====
src/yuv_stream_pkg.sv
src/stream_config.sv
src/yuv420_subsampler.sv
src/word_packer.sv
src/yuv420_stream.sv
tb/tb_clock_gen.sv
tb/yuv420_stream_properties.sv
tb/yuv420_stream_tb.sv
